/* alu_status.sv */
// ALU with decimal adjust and status register
`timescale 1ns/100ps
`default_nettype none
`include "mos_exec_cfg.svh"

module alu_status
    import mos_alu_pkg::*;
    import mos_isa_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   op_valid,
    input  logic                   use_operand,
    input  logic                   sets_nz,
    input  logic                   sets_c,
    input  logic                   sets_v,
    input  logic                   illegal,
    input  alu_op_t                alu_op,
    input  flag_op_t               flag_op,
    input  logic [`MOS_DATA_W-1:0] src_data,
    input  logic [`MOS_DATA_W-1:0] operand,
    output logic [`MOS_DATA_W-1:0] result,
    output status_t                status,
    output logic                   illegal_op
);

    logic [`MOS_DATA_W-1:0] b_in;        // Operand or zero
    logic [`MOS_DATA_W-1:0] add_b;       // Inverted for subtracts
    logic                   add_ci;
    logic [4:0]             low_sum;     // Low digit plus carry out
    logic [4:0]             high_sum;
    logic                   half_carry;
    logic                   carry_out;
    logic [`MOS_DATA_W-1:0] raw_sum;     // Before decimal adjust
    logic                   dec_add;
    logic                   dec_sub;
    logic                   arith;
    logic                   overflow;
    logic [3:0]             adj_lo;
    logic [3:0]             adj_hi;
    logic                   c_out;       // Carry or shifted-out bit
    logic [`MOS_DATA_W-1:0] nz_val;

    assign b_in    = use_operand ? operand : '0;
    assign dec_add = status.bits.d && (alu_op == ALU_ADC);
    assign dec_sub = status.bits.d && (alu_op == ALU_SBC);
    assign arith   = alu_op inside {ALU_ADC, ALU_SBC, ALU_CMP, ALU_INC, ALU_DEC};
    assign add_b   = (alu_op inside {ALU_SBC, ALU_CMP, ALU_DEC}) ? ~b_in : b_in;

    always_comb begin
        case (alu_op)
            ALU_ADC, ALU_SBC: add_ci = status.bits.c;
            ALU_DEC:          add_ci = 1'b0;   // A + FF
            default:          add_ci = 1'b1;   // CMP, INC
        endcase
    end

    // Split adder, decimal ADC carries between digits above 9
    assign low_sum    = {1'b0, src_data[3:0]} + {1'b0, add_b[3:0]} + {4'd0, add_ci};
    assign half_carry = dec_add ? (low_sum > 5'd9) : low_sum[4];
    assign high_sum   = {1'b0, src_data[7:4]} + {1'b0, add_b[7:4]} + {4'd0, half_carry};
    assign carry_out  = dec_add ? (high_sum > 5'd9) : high_sum[4];
    assign raw_sum    = {high_sum[3:0], low_sum[3:0]};
    assign overflow   = (src_data[7] == add_b[7]) && (raw_sum[7] != src_data[7]);

    always_comb begin
        adj_lo = 4'd0;
        adj_hi = 4'd0;
        if (dec_add) begin
            adj_lo = half_carry ? 4'd6 : 4'd0;   // Skip six unused codes
            adj_hi = carry_out  ? 4'd6 : 4'd0;
        end else if (dec_sub) begin
            adj_lo = half_carry ? 4'd0 : 4'd10;  // Borrow, minus six mod 16
            adj_hi = carry_out  ? 4'd0 : 4'd10;
        end
    end

    always_comb begin
        c_out  = carry_out;
        result = {raw_sum[7:4] + adj_hi, raw_sum[3:0] + adj_lo};
        case (alu_op)
            ALU_ORA:  result = src_data | b_in;
            ALU_AND:  result = src_data & b_in;
            ALU_EOR:  result = src_data ^ b_in;
            ALU_ASL:  {c_out, result} = {src_data, 1'b0};
            ALU_ROL:  {c_out, result} = {src_data, status.bits.c};
            ALU_LSR:  {result, c_out} = {1'b0, src_data};
            ALU_ROR:  {result, c_out} = {status.bits.c, src_data};
            ALU_PASS: result = use_operand ? b_in : src_data;  // Load or transfer
            default:  ;                                        // Adder group
        endcase
    end

    assign nz_val = arith ? raw_sum : result;   // N, Z from unadjusted sum

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            status     <= `MOS_STATUS_RESET;
            illegal_op <= 1'b0;
        end else begin
            illegal_op <= op_valid && illegal;  // One-cycle pulse
            if (op_valid) begin
                if (sets_nz) begin
                    status.bits.n <= nz_val[7];
                    status.bits.z <= (nz_val == '0);
                end
                if (sets_c) begin
                    status.bits.c <= c_out;
                end
                if (sets_v) begin
                    status.bits.v <= overflow;
                end
                case (flag_op)
                    FLAG_CLC: status.bits.c <= 1'b0;
                    FLAG_SEC: status.bits.c <= 1'b1;
                    FLAG_CLD: status.bits.d <= 1'b0;
                    FLAG_SED: status.bits.d <= 1'b1;
                    FLAG_CLV: status.bits.v <= 1'b0;
                    default:  ;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

/* flist.f */
+incdir+.
mos_alu_pkg.sv
mos_isa_pkg.sv
op_decoder.sv
reg_file.sv
alu_status.sv
mos_exec_unit.sv
tb_mos_exec_unit.sv

/* mos_alu_pkg.sv */
// ALU and status types
`default_nettype none
`include "mos_exec_cfg.svh"

package mos_alu_pkg;

    typedef enum logic [3:0] {
        ALU_ORA,                    // Logic ops on A and operand
        ALU_AND,
        ALU_EOR,
        ALU_ADC,                    // Adder group
        ALU_SBC,
        ALU_CMP,
        ALU_INC,
        ALU_DEC,
        ALU_ASL,                    // Shift group, C through the edge bit
        ALU_ROL,
        ALU_LSR,
        ALU_ROR,
        ALU_PASS                    // Loads and transfers
    } alu_op_t;

    // Register file index
    typedef enum logic [1:0] {
        SEL_A = 2'd0,
        SEL_S = 2'd1,
        SEL_X = 2'd2,
        SEL_Y = 2'd3
    } reg_sel_t;

    typedef struct packed {
        logic n;                    // Negative
        logic v;                    // Overflow
        logic one;                  // Always set
        logic brk;                  // Reads one
        logic d;                    // Decimal mode
        logic i;                    // Held clear in this core
        logic z;                    // Zero
        logic c;                    // Carry
    } status_bits_t;

    // P register, byte view leaves the core
    typedef union packed {
        logic [`MOS_DATA_W-1:0] raw;
        status_bits_t           bits;
    } status_t;

endpackage

`default_nettype wire

/* mos_exec_cfg.svh */
// Execute core configuration
`ifndef MOS_EXEC_CFG_SVH
`define MOS_EXEC_CFG_SVH

// Datapath width in bits
`define MOS_DATA_W 8

// Register reset values
`define MOS_S_RESET   8'hFF
`define MOS_AXY_RESET 8'h00

// All flags clear, bits 5 and 4 read one
`define MOS_STATUS_RESET 8'h30

`endif

/* mos_exec_unit.sv */
// 6502 execute core top level
`timescale 1ns/100ps
`default_nettype none
`include "mos_exec_cfg.svh"

module mos_exec_unit
    import mos_alu_pkg::*;
    import mos_isa_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   op_valid,      // One strobe per instruction
    input  logic [7:0]             opcode,
    input  logic [`MOS_DATA_W-1:0] operand,       // Immediate byte
    output logic [`MOS_DATA_W-1:0] a,
    output logic [`MOS_DATA_W-1:0] x,
    output logic [`MOS_DATA_W-1:0] y,
    output logic [`MOS_DATA_W-1:0] s,
    output logic [`MOS_DATA_W-1:0] status,
    output logic                   illegal_op
);

    alu_op_t                alu_op;
    reg_sel_t               src_sel;
    reg_sel_t               dst_sel;
    flag_op_t               flag_op;
    logic                   use_operand;
    logic                   load_reg;
    logic                   sets_nz;
    logic                   sets_c;
    logic                   sets_v;
    logic                   illegal;
    logic [`MOS_DATA_W-1:0] src_data;
    logic [`MOS_DATA_W-1:0] result;
    status_t                status_q;             // Flag view inside

    op_decoder u_op_decoder (
        .opcode      (opcode),
        .alu_op      (alu_op),
        .src_sel     (src_sel),
        .dst_sel     (dst_sel),
        .use_operand (use_operand),
        .load_reg    (load_reg),
        .sets_nz     (sets_nz),
        .sets_c      (sets_c),
        .sets_v      (sets_v),
        .flag_op     (flag_op),
        .illegal     (illegal)
    );

    reg_file u_reg_file (
        .clk      (clk),
        .reset    (reset),
        .op_valid (op_valid),
        .load_reg (load_reg),
        .src_sel  (src_sel),
        .dst_sel  (dst_sel),
        .result   (result),
        .src_data (src_data),
        .a        (a),
        .x        (x),
        .y        (y),
        .s        (s)
    );

    alu_status u_alu_status (
        .clk         (clk),
        .reset       (reset),
        .op_valid    (op_valid),
        .use_operand (use_operand),
        .sets_nz     (sets_nz),
        .sets_c      (sets_c),
        .sets_v      (sets_v),
        .illegal     (illegal),
        .alu_op      (alu_op),
        .flag_op     (flag_op),
        .src_data    (src_data),
        .operand     (operand),
        .result      (result),
        .status      (status_q),
        .illegal_op  (illegal_op)
    );

    assign status = status_q.raw;                 // Byte view on the port

endmodule

`default_nettype wire

/* mos_isa_pkg.sv */
// Supported opcodes and flag operations
`default_nettype none

package mos_isa_pkg;

    // Immediate mode
    localparam logic [7:0] OPC_ORA_IMM = 8'h09;
    localparam logic [7:0] OPC_AND_IMM = 8'h29;
    localparam logic [7:0] OPC_EOR_IMM = 8'h49;
    localparam logic [7:0] OPC_ADC_IMM = 8'h69;
    localparam logic [7:0] OPC_LDA_IMM = 8'hA9;
    localparam logic [7:0] OPC_CMP_IMM = 8'hC9;
    localparam logic [7:0] OPC_SBC_IMM = 8'hE9;
    localparam logic [7:0] OPC_LDY_IMM = 8'hA0;
    localparam logic [7:0] OPC_LDX_IMM = 8'hA2;
    localparam logic [7:0] OPC_CPY_IMM = 8'hC0;
    localparam logic [7:0] OPC_CPX_IMM = 8'hE0;

    // Transfers
    localparam logic [7:0] OPC_TXA = 8'h8A;
    localparam logic [7:0] OPC_TYA = 8'h98;
    localparam logic [7:0] OPC_TXS = 8'h9A;
    localparam logic [7:0] OPC_TAY = 8'hA8;
    localparam logic [7:0] OPC_TAX = 8'hAA;
    localparam logic [7:0] OPC_TSX = 8'hBA;

    // Index step
    localparam logic [7:0] OPC_DEY = 8'h88;
    localparam logic [7:0] OPC_INY = 8'hC8;
    localparam logic [7:0] OPC_DEX = 8'hCA;
    localparam logic [7:0] OPC_INX = 8'hE8;

    // Accumulator shifts
    localparam logic [7:0] OPC_ASL_A = 8'h0A;
    localparam logic [7:0] OPC_ROL_A = 8'h2A;
    localparam logic [7:0] OPC_LSR_A = 8'h4A;
    localparam logic [7:0] OPC_ROR_A = 8'h6A;

    // Flag instructions and NOP
    localparam logic [7:0] OPC_CLC = 8'h18;
    localparam logic [7:0] OPC_SEC = 8'h38;
    localparam logic [7:0] OPC_CLV = 8'hB8;
    localparam logic [7:0] OPC_CLD = 8'hD8;
    localparam logic [7:0] OPC_SED = 8'hF8;
    localparam logic [7:0] OPC_NOP = 8'hEA;

    typedef enum logic [2:0] {
        FLAG_NONE,
        FLAG_CLC,
        FLAG_SEC,
        FLAG_CLD,
        FLAG_SED,
        FLAG_CLV
    } flag_op_t;

endpackage

`default_nettype wire

/* op_decoder.sv */
// Opcode decoder
`timescale 1ns/100ps
`default_nettype none

module op_decoder
    import mos_alu_pkg::*;
    import mos_isa_pkg::*;
(
    input  logic [7:0] opcode,
    output alu_op_t    alu_op,
    output reg_sel_t   src_sel,
    output reg_sel_t   dst_sel,
    output logic       use_operand,
    output logic       load_reg,
    output logic       sets_nz,
    output logic       sets_c,
    output logic       sets_v,
    output flag_op_t   flag_op,
    output logic       illegal
);

    // Source register from row/column pattern, first match wins
    always_comb begin
        casez (opcode)
            8'b1011_1010:                       src_sel = SEL_S;  // TSX
            8'b100?_1?10, 8'b1110_??00,
            8'b1100_1010:                       src_sel = SEL_X;  // TXA TXS INX CPX DEX
            8'b1001_1000, 8'b1100_??00,
            8'b1?00_1000:                       src_sel = SEL_Y;  // TYA CPY INY DEY
            default:                            src_sel = SEL_A;
        endcase
    end

    // Destination register
    always_comb begin
        casez (opcode)
            8'b1110_1000, 8'b1100_1010,
            8'b101?_??10:                       dst_sel = SEL_X;  // INX DEX LDX TAX TSX
            8'b1001_1010:                       dst_sel = SEL_S;  // TXS
            8'b1?00_1000, 8'b1010_?000:         dst_sel = SEL_Y;  // DEY INY LDY TAY
            default:                            dst_sel = SEL_A;
        endcase
    end

    always_comb begin
        alu_op      = ALU_PASS;
        use_operand = 1'b0;
        load_reg    = 1'b0;
        sets_nz     = 1'b0;
        sets_c      = 1'b0;
        sets_v      = 1'b0;
        flag_op     = FLAG_NONE;
        illegal     = 1'b0;
        case (opcode)
            OPC_ORA_IMM, OPC_AND_IMM, OPC_EOR_IMM,
            OPC_ADC_IMM, OPC_SBC_IMM, OPC_LDA_IMM: begin  // Column 9 group
                use_operand = 1'b1;
                load_reg    = 1'b1;
                sets_nz     = 1'b1;
                sets_c      = opcode[6] & opcode[5];      // ADC, SBC only
                sets_v      = opcode[6] & opcode[5];
                case (opcode[7:5])                        // Row picks the op
                    3'b000:  alu_op = ALU_ORA;
                    3'b001:  alu_op = ALU_AND;
                    3'b010:  alu_op = ALU_EOR;
                    3'b011:  alu_op = ALU_ADC;
                    3'b111:  alu_op = ALU_SBC;
                    default: alu_op = ALU_PASS;           // LDA
                endcase
            end
            OPC_CMP_IMM, OPC_CPX_IMM, OPC_CPY_IMM: begin  // Flags only
                alu_op      = ALU_CMP;
                use_operand = 1'b1;
                sets_nz     = 1'b1;
                sets_c      = 1'b1;
            end
            OPC_LDX_IMM, OPC_LDY_IMM: begin
                use_operand = 1'b1;
                load_reg    = 1'b1;
                sets_nz     = 1'b1;
            end
            OPC_TAX, OPC_TXA, OPC_TAY, OPC_TYA, OPC_TSX: begin
                load_reg = 1'b1;
                sets_nz  = 1'b1;
            end
            OPC_TXS: load_reg = 1'b1;                     // S write, no flags
            OPC_INX, OPC_INY, OPC_DEX, OPC_DEY: begin
                alu_op   = (opcode == OPC_INX || opcode == OPC_INY) ? ALU_INC : ALU_DEC;
                load_reg = 1'b1;
                sets_nz  = 1'b1;
            end
            OPC_ASL_A, OPC_ROL_A, OPC_LSR_A, OPC_ROR_A: begin
                load_reg = 1'b1;
                sets_nz  = 1'b1;
                sets_c   = 1'b1;
                case (opcode[6:5])                        // Right shift, rotate
                    2'b00:   alu_op = ALU_ASL;
                    2'b01:   alu_op = ALU_ROL;
                    2'b10:   alu_op = ALU_LSR;
                    default: alu_op = ALU_ROR;
                endcase
            end
            OPC_CLC: flag_op = FLAG_CLC;
            OPC_SEC: flag_op = FLAG_SEC;
            OPC_CLD: flag_op = FLAG_CLD;
            OPC_SED: flag_op = FLAG_SED;
            OPC_CLV: flag_op = FLAG_CLV;
            OPC_NOP: ;                                    // Strobe accepted, no effect
            default: illegal = 1'b1;                      // Memory modes and the rest
        endcase
    end

endmodule

`default_nettype wire

/* reg_file.sv */
// A, X, Y and S register file
`timescale 1ns/100ps
`default_nettype none
`include "mos_exec_cfg.svh"

module reg_file
    import mos_alu_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   op_valid,
    input  logic                   load_reg,
    input  reg_sel_t               src_sel,
    input  reg_sel_t               dst_sel,
    input  logic [`MOS_DATA_W-1:0] result,
    output logic [`MOS_DATA_W-1:0] src_data,
    output logic [`MOS_DATA_W-1:0] a,
    output logic [`MOS_DATA_W-1:0] x,
    output logic [`MOS_DATA_W-1:0] y,
    output logic [`MOS_DATA_W-1:0] s
);

    logic [`MOS_DATA_W-1:0] axys [4];  // Indexed by reg_sel_t

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            axys[SEL_A] <= `MOS_AXY_RESET;
            axys[SEL_S] <= `MOS_S_RESET;     // Stack starts at top of page
            axys[SEL_X] <= `MOS_AXY_RESET;
            axys[SEL_Y] <= `MOS_AXY_RESET;
        end else if (op_valid && load_reg) begin
            axys[dst_sel] <= result;         // One write per strobe
        end
    end

    assign src_data = axys[src_sel];         // ALU A side

    assign a = axys[SEL_A];
    assign x = axys[SEL_X];
    assign y = axys[SEL_Y];
    assign s = axys[SEL_S];

    a_dst_known: assert property (@(posedge clk) disable iff (reset)
        op_valid |-> !$isunknown(dst_sel))
        else $error("reg_file: unknown dst_sel on strobe");

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# Build and run the execute core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal \
    --top-module tb_mos_exec_unit \
    --Mdir obj_dir -o tb_mos_exec_unit \
    -f flist.f

./obj_dir/tb_mos_exec_unit > sim.log 2>&1
cat sim.log

if grep -q "Result: FAILED" sim.log; then
    echo "Simulation reported a failure, see sim.log"
    exit 1
fi
echo "Simulation finished without failure"

/* tb_mos_exec_unit.sv */
// Execute core testbench
`timescale 1ns/100ps
`default_nettype none

module tb_mos_exec_unit
    import mos_isa_pkg::*;
();

    localparam int N_BIN = 40;                  // Random binary add/compare rounds
    localparam int N_DEC = 30;                  // Random BCD rounds

    typedef struct packed {
        logic [7:0] op;
        logic [7:0] opd;
        logic [7:0] a;
        logic [7:0] x;
        logic [7:0] y;
        logic [7:0] s;
        logic [7:0] p;
        logic       ill;
    } row_t;

    logic       clk;
    logic       reset;
    logic       op_valid;
    logic [7:0] opcode;
    logic [7:0] operand;
    logic [7:0] a;
    logic [7:0] x;
    logic [7:0] y;
    logic [7:0] s;
    logic [7:0] status;
    logic       illegal_op;

    row_t       table_q[$];                     // Directed rows
    int         check_count = 0;
    int         error_count = 0;
    int         cycle_count = 0;
    int         cycle_limit = 0;                // Zero until worked out

    logic [7:0] m_a;                            // Reference model state
    logic [7:0] m_x;
    logic [7:0] m_y;
    logic [7:0] m_s;
    logic [7:0] m_p;
    logic [7:0] m_mask;                         // Status bits the model predicts
    logic       m_ill;

    mos_exec_unit u_mos_exec_unit (
        .clk        (clk),
        .reset      (reset),
        .op_valid   (op_valid),
        .opcode     (opcode),
        .operand    (operand),
        .a          (a),
        .x          (x),
        .y          (y),
        .s          (s),
        .status     (status),
        .illegal_op (illegal_op)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;                 // 100 ns period
    end

    // Run limit guard
    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("Timeout: run did not complete within %0d cycles", cycle_limit);
            $display("Result: FAILED");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [7:0] actual,
                               input logic [7:0] expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("Error: time %0t signal %s actual 8'h%h expected 8'h%h",
                     $time, name, actual, expected);
        end
    endtask

    task automatic verify_outputs(input logic [7:0] ea, input logic [7:0] ex,
                                  input logic [7:0] ey, input logic [7:0] es,
                                  input logic [7:0] ep, input logic [7:0] pmask,
                                  input logic eill);
        check_value("a", a, ea);
        check_value("x", x, ex);
        check_value("y", y, ey);
        check_value("s", s, es);
        check_value("status", status & pmask, ep & pmask);   // Masked where unpredicted
        check_value("illegal_op", {7'd0, illegal_op}, {7'd0, eill});
    endtask

    task automatic close_test(input string name, input int start_errors);
        $display("Test %s: %s, %0d errors", name,
                 (error_count == start_errors) ? "ok" : "failed", error_count - start_errors);
    endtask

    // Drive on the falling edge, return at the next one
    task automatic apply_strobe(input logic [7:0] op, input logic [7:0] opd);
        op_valid = 1'b1;
        opcode   = op;
        operand  = opd;
        @(negedge clk);
    endtask

    task automatic add_row(input logic [7:0] op, input logic [7:0] opd, input logic [7:0] ea,
                           input logic [7:0] ex, input logic [7:0] ey, input logic [7:0] es,
                           input logic [7:0] ep, input logic eill);
        table_q.push_back({op, opd, ea, ex, ey, es, ep, eill});
    endtask

    task automatic build_table();
        // Loads, transfers, index steps with wrap
        add_row(OPC_LDA_IMM, 8'h80, 8'h80, 8'h00, 8'h00, 8'hFF, 8'hB0, 1'b0);
        add_row(OPC_TAX,     8'hA5, 8'h80, 8'h80, 8'h00, 8'hFF, 8'hB0, 1'b0);
        add_row(OPC_LDY_IMM, 8'h00, 8'h80, 8'h80, 8'h00, 8'hFF, 8'h32, 1'b0);
        add_row(OPC_INY,     8'hA5, 8'h80, 8'h80, 8'h01, 8'hFF, 8'h30, 1'b0);
        add_row(OPC_DEY,     8'hA5, 8'h80, 8'h80, 8'h00, 8'hFF, 8'h32, 1'b0);
        add_row(OPC_DEY,     8'hA5, 8'h80, 8'h80, 8'hFF, 8'hFF, 8'hB0, 1'b0);
        add_row(OPC_INY,     8'hA5, 8'h80, 8'h80, 8'h00, 8'hFF, 8'h32, 1'b0);
        add_row(OPC_LDX_IMM, 8'hFF, 8'h80, 8'hFF, 8'h00, 8'hFF, 8'hB0, 1'b0);
        add_row(OPC_INX,     8'hA5, 8'h80, 8'h00, 8'h00, 8'hFF, 8'h32, 1'b0);
        add_row(OPC_DEX,     8'hA5, 8'h80, 8'hFF, 8'h00, 8'hFF, 8'hB0, 1'b0);
        add_row(OPC_LDX_IMM, 8'h41, 8'h80, 8'h41, 8'h00, 8'hFF, 8'h30, 1'b0);
        add_row(OPC_LDA_IMM, 8'h00, 8'h00, 8'h41, 8'h00, 8'hFF, 8'h32, 1'b0);
        add_row(OPC_TXS,     8'hA5, 8'h00, 8'h41, 8'h00, 8'h41, 8'h32, 1'b0);  // Z kept
        add_row(OPC_DEX,     8'hA5, 8'h00, 8'h40, 8'h00, 8'h41, 8'h30, 1'b0);
        add_row(OPC_TSX,     8'hA5, 8'h00, 8'h41, 8'h00, 8'h41, 8'h30, 1'b0);
        add_row(OPC_TXA,     8'hA5, 8'h41, 8'h41, 8'h00, 8'h41, 8'h30, 1'b0);
        add_row(OPC_LDY_IMM, 8'hC3, 8'h41, 8'h41, 8'hC3, 8'h41, 8'hB0, 1'b0);
        add_row(OPC_TYA,     8'hA5, 8'hC3, 8'h41, 8'hC3, 8'h41, 8'hB0, 1'b0);
        add_row(OPC_LDA_IMM, 8'h05, 8'h05, 8'h41, 8'hC3, 8'h41, 8'h30, 1'b0);
        add_row(OPC_TAY,     8'hA5, 8'h05, 8'h41, 8'h05, 8'h41, 8'h30, 1'b0);
        // Logic ops
        add_row(OPC_ORA_IMM, 8'hF0, 8'hF5, 8'h41, 8'h05, 8'h41, 8'hB0, 1'b0);
        add_row(OPC_AND_IMM, 8'h0F, 8'h05, 8'h41, 8'h05, 8'h41, 8'h30, 1'b0);
        add_row(OPC_EOR_IMM, 8'h05, 8'h00, 8'h41, 8'h05, 8'h41, 8'h32, 1'b0);
        add_row(OPC_EOR_IMM, 8'h81, 8'h81, 8'h41, 8'h05, 8'h41, 8'hB0, 1'b0);
        // Shifts and rotates, C through bit 7 and bit 0
        add_row(OPC_ASL_A,   8'hA5, 8'h02, 8'h41, 8'h05, 8'h41, 8'h31, 1'b0);
        add_row(OPC_ROL_A,   8'hA5, 8'h05, 8'h41, 8'h05, 8'h41, 8'h30, 1'b0);
        add_row(OPC_LSR_A,   8'hA5, 8'h02, 8'h41, 8'h05, 8'h41, 8'h31, 1'b0);
        add_row(OPC_ROR_A,   8'hA5, 8'h81, 8'h41, 8'h05, 8'h41, 8'hB0, 1'b0);
        add_row(OPC_ROR_A,   8'hA5, 8'h40, 8'h41, 8'h05, 8'h41, 8'h31, 1'b0);
        add_row(OPC_ROL_A,   8'hA5, 8'h81, 8'h41, 8'h05, 8'h41, 8'hB0, 1'b0);
        add_row(OPC_LSR_A,   8'hA5, 8'h40, 8'h41, 8'h05, 8'h41, 8'h31, 1'b0);
        add_row(OPC_ASL_A,   8'hA5, 8'h80, 8'h41, 8'h05, 8'h41, 8'hB0, 1'b0);
        add_row(OPC_ASL_A,   8'hA5, 8'h00, 8'h41, 8'h05, 8'h41, 8'h33, 1'b0);
        // Flag instructions
        add_row(OPC_CLC,     8'hA5, 8'h00, 8'h41, 8'h05, 8'h41, 8'h32, 1'b0);
        add_row(OPC_SEC,     8'hA5, 8'h00, 8'h41, 8'h05, 8'h41, 8'h33, 1'b0);
        add_row(OPC_SED,     8'hA5, 8'h00, 8'h41, 8'h05, 8'h41, 8'h3B, 1'b0);
        add_row(OPC_CLD,     8'hA5, 8'h00, 8'h41, 8'h05, 8'h41, 8'h33, 1'b0);
        // Unsupported opcodes back to back, then NOP
        add_row(8'h00,       8'h00, 8'h00, 8'h41, 8'h05, 8'h41, 8'h33, 1'b1);
        add_row(8'hAD,       8'h12, 8'h00, 8'h41, 8'h05, 8'h41, 8'h33, 1'b1);  // LDA abs
        add_row(OPC_NOP,     8'hA5, 8'h00, 8'h41, 8'h05, 8'h41, 8'h33, 1'b0);
        // Overflow, CLV, compares
        add_row(OPC_ADC_IMM, 8'h7F, 8'h80, 8'h41, 8'h05, 8'h41, 8'hF0, 1'b0);
        add_row(OPC_CLV,     8'hA5, 8'h80, 8'h41, 8'h05, 8'h41, 8'hB0, 1'b0);
        add_row(OPC_CMP_IMM, 8'h80, 8'h80, 8'h41, 8'h05, 8'h41, 8'h33, 1'b0);
        add_row(OPC_CPX_IMM, 8'h42, 8'h80, 8'h41, 8'h05, 8'h41, 8'hB0, 1'b0);
        add_row(OPC_CPY_IMM, 8'h05, 8'h80, 8'h41, 8'h05, 8'h41, 8'h33, 1'b0);
        add_row(8'h02,       8'h77, 8'h80, 8'h41, 8'h05, 8'h41, 8'h33, 1'b1);
    endtask

    function automatic int bcd_to_int(input logic [7:0] v);
        return 10 * int'(v[7:4]) + int'(v[3:0]);
    endfunction

    function automatic logic [7:0] int_to_bcd(input int v);
        return {4'(v / 10), 4'(v % 10)};
    endfunction

    task automatic update_nz(input logic [7:0] v);
        m_p[7]    = v[7];
        m_p[1]    = (v == 8'h00);
        m_mask[7] = 1'b1;
        m_mask[1] = 1'b1;
    endtask

    task automatic cmp_flags(input logic [7:0] r, input logic [7:0] opd);
        logic [7:0] diff;
        diff   = r - opd;
        m_p[0] = (r >= opd);                    // No borrow
        update_nz(diff);
    endtask

    // Model of the opcodes used in the random sections
    task automatic model_step(input logic [7:0] op, input logic [7:0] opd);
        logic [8:0] sum;
        int         dr;
        m_ill = 1'b0;
        case (op)
            OPC_CLC: m_p[0] = 1'b0;
            OPC_SEC: m_p[0] = 1'b1;
            OPC_CLD: m_p[3] = 1'b0;
            OPC_SED: m_p[3] = 1'b1;
            OPC_LDA_IMM: begin
                m_a = opd;
                update_nz(opd);
            end
            OPC_LDX_IMM: begin
                m_x = opd;
                update_nz(opd);
            end
            OPC_LDY_IMM: begin
                m_y = opd;
                update_nz(opd);
            end
            OPC_CMP_IMM: cmp_flags(m_a, opd);
            OPC_CPX_IMM: cmp_flags(m_x, opd);
            OPC_CPY_IMM: cmp_flags(m_y, opd);
            OPC_ADC_IMM: begin
                if (m_p[3]) begin
                    dr     = bcd_to_int(m_a) + bcd_to_int(opd) + int'(m_p[0]);
                    m_p[0] = (dr > 99);
                    m_a    = int_to_bcd(dr % 100);
                    m_mask = m_mask & 8'h3D;    // N, V, Z not predicted in BCD
                end else begin
                    sum       = {1'b0, m_a} + {1'b0, opd} + {8'd0, m_p[0]};
                    m_p[6]    = (m_a[7] == opd[7]) && (sum[7] != m_a[7]);
                    m_p[0]    = sum[8];
                    m_a       = sum[7:0];
                    m_mask[6] = 1'b1;
                    update_nz(m_a);
                end
            end
            OPC_SBC_IMM: begin
                if (m_p[3]) begin
                    dr     = bcd_to_int(m_a) - bcd_to_int(opd) - int'(!m_p[0]);
                    m_p[0] = (dr >= 0);
                    m_a    = int_to_bcd((dr < 0) ? dr + 100 : dr);
                    m_mask = m_mask & 8'h3D;
                end else begin
                    sum       = {1'b0, m_a} - {1'b0, opd} - {8'd0, ~m_p[0]};
                    m_p[6]    = (m_a[7] != opd[7]) && (sum[7] != m_a[7]);
                    m_p[0]    = ~sum[8];            // Borrow inverted
                    m_a       = sum[7:0];
                    m_mask[6] = 1'b1;
                    update_nz(m_a);
                end
            end
            default: m_ill = 1'b1;
        endcase
    endtask

    task automatic run_strobe(input logic [7:0] op, input logic [7:0] opd);
        apply_strobe(op, opd);
        model_step(op, opd);
        verify_outputs(m_a, m_x, m_y, m_s, m_p, m_mask, m_ill);
    endtask

    initial begin
        int         seed_val;
        int         start_errors;
        int         kind;
        int         strobes;
        logic [7:0] r1;
        logic [7:0] r2;
        logic       cin;
        logic       sub;
        seed_val = $urandom(32'h0f96b41a);
        reset    = 1'b1;
        op_valid = 1'b0;
        opcode   = 8'h00;
        operand  = 8'h00;
        build_table();
        strobes     = table_q.size() + 3 * N_BIN + 3 * N_DEC + 5;
        cycle_limit = 2 * strobes + 8 + 50;
        repeat (8) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);

        start_errors = error_count;
        verify_outputs(8'h00, 8'h00, 8'h00, 8'hFF, 8'h30, 8'hFF, 1'b0);
        close_test("reset values", start_errors);

        start_errors = error_count;
        foreach (table_q[i]) begin
            apply_strobe(table_q[i].op, table_q[i].opd);
            verify_outputs(table_q[i].a, table_q[i].x, table_q[i].y, table_q[i].s,
                           table_q[i].p, 8'hFF, table_q[i].ill);
        end
        op_valid = 1'b0;
        repeat (2) @(negedge clk);              // Idle, state must hold
        verify_outputs(table_q[$].a, table_q[$].x, table_q[$].y, table_q[$].s,
                       table_q[$].p, 8'hFF, 1'b0);
        close_test("directed table", start_errors);

        m_a    = table_q[$].a;
        m_x    = table_q[$].x;
        m_y    = table_q[$].y;
        m_s    = table_q[$].s;
        m_p    = table_q[$].p;
        m_mask = 8'hFF;
        start_errors = error_count;
        for (int i = 0; i < N_BIN; i++) begin
            r1   = 8'($urandom);
            r2   = 8'($urandom);
            cin  = 1'($urandom);
            kind = $urandom % 5;
            run_strobe(cin ? OPC_SEC : OPC_CLC, 8'h00);
            case (kind)
                3: begin
                    run_strobe(OPC_LDX_IMM, r1);
                    run_strobe(OPC_CPX_IMM, r2);
                end
                4: begin
                    run_strobe(OPC_LDY_IMM, r1);
                    run_strobe(OPC_CPY_IMM, r2);
                end
                default: begin
                    run_strobe(OPC_LDA_IMM, r1);
                    run_strobe((kind == 0) ? OPC_ADC_IMM :
                               (kind == 1) ? OPC_SBC_IMM : OPC_CMP_IMM, r2);
                end
            endcase
        end
        close_test("binary arithmetic", start_errors);

        start_errors = error_count;
        run_strobe(OPC_SED, 8'h00);
        for (int i = 0; i < N_DEC; i++) begin
            r1  = {4'($urandom % 10), 4'($urandom % 10)};   // Valid BCD only
            r2  = {4'($urandom % 10), 4'($urandom % 10)};
            cin = 1'($urandom);
            sub = 1'($urandom);
            run_strobe(cin ? OPC_SEC : OPC_CLC, 8'h00);
            run_strobe(OPC_LDA_IMM, r1);
            run_strobe(sub ? OPC_SBC_IMM : OPC_ADC_IMM, r2);
        end
        run_strobe(OPC_CLD, 8'h00);
        run_strobe(OPC_CLC, 8'h00);
        run_strobe(OPC_LDA_IMM, 8'h09);
        run_strobe(OPC_ADC_IMM, 8'h01);         // Binary again, 8'h0A
        op_valid = 1'b0;
        close_test("decimal mode", start_errors);

        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
